// ==== rtl/idu_config.svh ====
`ifndef IDU_CONFIG_SVH
`define IDU_CONFIG_SVH

`define XLEN        32
`define GPR_ADDR_W  5
`define GPR_NUM     32
`define RA_REG      1     // link register for bl

// one-hot alu op, bit positions
`define ALU_OP_W    12
`define ALU_ADD     0
`define ALU_SUB     1
`define ALU_SLT     2
`define ALU_SLTU    3
`define ALU_AND     4
`define ALU_NOR     5
`define ALU_OR      6
`define ALU_XOR     7
`define ALU_SLL     8
`define ALU_SRL     9
`define ALU_SRA     10
`define ALU_LUI     11

`define BR_KIND_W   4
`define BR_NONE     4'd0
`define BR_EQ       4'd1
`define BR_NE       4'd2
`define BR_LT       4'd3
`define BR_GE       4'd4
`define BR_LTU      4'd5
`define BR_GEU      4'd6
`define BR_ALWAYS   4'd7  // b and bl
`define BR_JIRL     4'd8

`endif

// ==== rtl/idu_pkg.sv ====
`include "idu_config.svh"

package idu_pkg;

  // three-register format
  typedef struct packed {
    logic [16:0]            opcode;
    logic [`GPR_ADDR_W-1:0] rk;
    logic [`GPR_ADDR_W-1:0] rj;
    logic [`GPR_ADDR_W-1:0] rd;
  } r3_fmt_t;

  typedef struct packed {
    logic [9:0]             opcode;
    logic [11:0]            imm;    // si12 or ui12, ui5 for shifts
    logic [`GPR_ADDR_W-1:0] rj;
    logic [`GPR_ADDR_W-1:0] rd;
  } ri12_fmt_t;

  // branches; b and bl use {rj, rd, offs} as a 26-bit offset
  typedef struct packed {
    logic [5:0]             opcode;
    logic [15:0]            offs;
    logic [`GPR_ADDR_W-1:0] rj;
    logic [`GPR_ADDR_W-1:0] rd;
  } ri16_fmt_t;

  typedef struct packed {
    logic [6:0]             opcode;
    logic [19:0]            imm;
    logic [`GPR_ADDR_W-1:0] rd;
  } ri20_fmt_t;

  typedef union packed {
    r3_fmt_t   r3;
    ri12_fmt_t ri12;
    ri16_fmt_t ri16;
    ri20_fmt_t ri20;
  } inst_word_u;

endpackage

// ==== rtl/gpr_file.sv ====
`timescale 1ns/100ps
`include "idu_config.svh"

module gpr_file (
  input  logic                   clk,
  input  logic [`GPR_ADDR_W-1:0] raddr1,
  input  logic [`GPR_ADDR_W-1:0] raddr2,
  input  logic                   we,
  input  logic [`GPR_ADDR_W-1:0] waddr,
  input  logic [`XLEN-1:0]       wdata,
  output logic [`XLEN-1:0]       rdata1,
  output logic [`XLEN-1:0]       rdata2
);

  logic [`XLEN-1:0] regs [`GPR_NUM];

  always_ff @(posedge clk) begin
    if (we && (waddr != '0)) begin   // r0 is hardwired
      regs[waddr] <= wdata;
    end
  end

  // combinational reads, write visible after the edge
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== rtl/inst_decoder.sv ====
`timescale 1ns/100ps
`include "idu_config.svh"

module inst_decoder import idu_pkg::*; (
  input  inst_word_u             inst,
  output logic [`ALU_OP_W-1:0]   alu_op,
  output logic                   src1_is_pc,
  output logic                   src2_is_imm,
  output logic                   use_rj,
  output logic                   use_rkd,
  output logic                   rkd_is_rd,
  output logic                   load,
  output logic                   store,
  output logic                   rf_we,
  output logic [`GPR_ADDR_W-1:0] rf_waddr,
  output logic [`XLEN-1:0]       imm,
  output logic [`BR_KIND_W-1:0]  br_kind
);

  logic is_add, is_sub, is_slt, is_sltu, is_and, is_or, is_nor, is_xor;
  logic is_sll, is_srl, is_sra, is_slli, is_srli, is_srai;
  logic is_addi, is_slti, is_sltui, is_andi, is_ori, is_xori;
  logic is_lu12i, is_pcadd, is_ld, is_st;
  logic is_jirl, is_b, is_bl, is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu;
  logic alu_reg;      // register-register alu ops
  logic alu_imm;      // register-immediate alu ops
  logic br_cond;      // conditional branches
  logic need_si12;
  logic need_ui12;

  // opcode match per format view
  assign is_add   = inst.r3.opcode == 17'h00020;
  assign is_sub   = inst.r3.opcode == 17'h00022;
  assign is_slt   = inst.r3.opcode == 17'h00024;
  assign is_sltu  = inst.r3.opcode == 17'h00025;
  assign is_nor   = inst.r3.opcode == 17'h00028;
  assign is_and   = inst.r3.opcode == 17'h00029;
  assign is_or    = inst.r3.opcode == 17'h0002a;
  assign is_xor   = inst.r3.opcode == 17'h0002b;
  assign is_sll   = inst.r3.opcode == 17'h0002e;
  assign is_srl   = inst.r3.opcode == 17'h0002f;
  assign is_sra   = inst.r3.opcode == 17'h00030;
  assign is_slli  = inst.r3.opcode == 17'h00081;  // ui5 sits in rk
  assign is_srli  = inst.r3.opcode == 17'h00089;
  assign is_srai  = inst.r3.opcode == 17'h00091;

  assign is_slti  = inst.ri12.opcode == 10'h008;
  assign is_sltui = inst.ri12.opcode == 10'h009;
  assign is_addi  = inst.ri12.opcode == 10'h00a;
  assign is_andi  = inst.ri12.opcode == 10'h00d;
  assign is_ori   = inst.ri12.opcode == 10'h00e;
  assign is_xori  = inst.ri12.opcode == 10'h00f;
  assign is_ld    = inst.ri12.opcode == 10'h0a2;
  assign is_st    = inst.ri12.opcode == 10'h0a6;

  assign is_lu12i = inst.ri20.opcode == 7'h0a;
  assign is_pcadd = inst.ri20.opcode == 7'h0e;

  assign is_jirl  = inst.ri16.opcode == 6'h13;
  assign is_b     = inst.ri16.opcode == 6'h14;
  assign is_bl    = inst.ri16.opcode == 6'h15;
  assign is_beq   = inst.ri16.opcode == 6'h16;
  assign is_bne   = inst.ri16.opcode == 6'h17;
  assign is_blt   = inst.ri16.opcode == 6'h18;
  assign is_bge   = inst.ri16.opcode == 6'h19;
  assign is_bltu  = inst.ri16.opcode == 6'h1a;
  assign is_bgeu  = inst.ri16.opcode == 6'h1b;

  assign alu_reg = is_add | is_sub | is_slt | is_sltu | is_and | is_or | is_nor | is_xor
                 | is_sll | is_srl | is_sra;
  assign alu_imm = is_slli | is_srli | is_srai | is_addi | is_slti | is_sltui
                 | is_andi | is_ori | is_xori;
  assign br_cond = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;

  always_comb begin
    alu_op = '0;
    alu_op[`ALU_ADD]  = is_add | is_addi | is_ld | is_st | is_jirl | is_bl | is_pcadd;
    alu_op[`ALU_SUB]  = is_sub;
    alu_op[`ALU_SLT]  = is_slt | is_slti;
    alu_op[`ALU_SLTU] = is_sltu | is_sltui;
    alu_op[`ALU_AND]  = is_and | is_andi;
    alu_op[`ALU_NOR]  = is_nor;
    alu_op[`ALU_OR]   = is_or | is_ori;
    alu_op[`ALU_XOR]  = is_xor | is_xori;
    alu_op[`ALU_SLL]  = is_sll | is_slli;
    alu_op[`ALU_SRL]  = is_srl | is_srli;
    alu_op[`ALU_SRA]  = is_sra | is_srai;
    alu_op[`ALU_LUI]  = is_lu12i;
  end

  assign need_si12 = is_addi | is_slti | is_sltui | is_ld | is_st
                   | is_slli | is_srli | is_srai;
  assign need_ui12 = is_andi | is_ori | is_xori;

  always_comb begin
    if (is_jirl || is_bl) begin
      imm = `XLEN'(4);                                      // link address pc+4
    end else if (is_lu12i || is_pcadd) begin
      imm = {inst.ri20.imm, 12'b0};
    end else if (need_si12) begin
      imm = {{(`XLEN-12){inst.ri12.imm[11]}}, inst.ri12.imm};
    end else if (need_ui12) begin
      imm = {{(`XLEN-12){1'b0}}, inst.ri12.imm};
    end else begin
      imm = '0;
    end
  end

  assign src1_is_pc  = is_jirl | is_bl | is_pcadd;
  assign src2_is_imm = alu_imm | is_ld | is_st | is_lu12i | is_pcadd | is_jirl | is_bl;
  assign use_rj      = alu_reg | alu_imm | is_ld | is_st | is_jirl | br_cond;
  assign use_rkd     = alu_reg | is_st | br_cond;
  assign rkd_is_rd   = is_st | br_cond;  // rd is a source here
  assign load        = is_ld;
  assign store       = is_st;
  assign rf_we       = alu_reg | alu_imm | is_lu12i | is_pcadd | is_ld | is_jirl | is_bl;

  // zero when nothing is written back
  assign rf_waddr = !rf_we ? '0
                  : is_bl  ? `GPR_ADDR_W'(`RA_REG)
                  : inst.r3.rd;

  always_comb begin
    br_kind = `BR_NONE;
    if (is_beq)              br_kind = `BR_EQ;
    else if (is_bne)         br_kind = `BR_NE;
    else if (is_blt)         br_kind = `BR_LT;
    else if (is_bge)         br_kind = `BR_GE;
    else if (is_bltu)        br_kind = `BR_LTU;
    else if (is_bgeu)        br_kind = `BR_GEU;
    else if (is_b || is_bl)  br_kind = `BR_ALWAYS;
    else if (is_jirl)        br_kind = `BR_JIRL;
  end

endmodule

// ==== rtl/operand_bypass.sv ====
`timescale 1ns/100ps
`include "idu_config.svh"

module operand_bypass (
  input  logic [`GPR_ADDR_W-1:0] raddr1,
  input  logic [`GPR_ADDR_W-1:0] raddr2,
  input  logic [`XLEN-1:0]       rdata1,
  input  logic [`XLEN-1:0]       rdata2,
  input  logic                   use_rj,
  input  logic                   use_rkd,
  input  logic                   ex_fwd_we,
  input  logic                   ex_fwd_is_load,
  input  logic [`GPR_ADDR_W-1:0] ex_fwd_waddr,
  input  logic [`XLEN-1:0]       ex_fwd_wdata,
  input  logic                   mem_fwd_we,
  input  logic [`GPR_ADDR_W-1:0] mem_fwd_waddr,
  input  logic [`XLEN-1:0]       mem_fwd_wdata,
  input  logic                   wb_we,
  input  logic [`GPR_ADDR_W-1:0] wb_waddr,
  input  logic [`XLEN-1:0]       wb_wdata,
  output logic [`XLEN-1:0]       rj_value,
  output logic [`XLEN-1:0]       rkd_value,
  output logic                   stall
);

  logic rj_ex, rj_mem, rj_wb;
  logic rkd_ex, rkd_mem, rkd_wb;

  // a source hits when it writes the register being read, never r0
  function automatic logic src_hit(input logic                   we,
                                   input logic [`GPR_ADDR_W-1:0] waddr,
                                   input logic [`GPR_ADDR_W-1:0] raddr);
    return we && (waddr == raddr) && (raddr != '0);
  endfunction

  assign rj_ex   = src_hit(ex_fwd_we, ex_fwd_waddr, raddr1);
  assign rj_mem  = src_hit(mem_fwd_we, mem_fwd_waddr, raddr1);
  assign rj_wb   = src_hit(wb_we, wb_waddr, raddr1);
  assign rkd_ex  = src_hit(ex_fwd_we, ex_fwd_waddr, raddr2);
  assign rkd_mem = src_hit(mem_fwd_we, mem_fwd_waddr, raddr2);
  assign rkd_wb  = src_hit(wb_we, wb_waddr, raddr2);

  // youngest producer wins
  assign rj_value  = rj_ex   ? ex_fwd_wdata
                   : rj_mem  ? mem_fwd_wdata
                   : rj_wb   ? wb_wdata
                   : rdata1;
  assign rkd_value = rkd_ex  ? ex_fwd_wdata
                   : rkd_mem ? mem_fwd_wdata
                   : rkd_wb  ? wb_wdata
                   : rdata2;

  // load data is not ready until MEM, so wait a cycle
  assign stall = ex_fwd_is_load & ((use_rj & rj_ex) | (use_rkd & rkd_ex));

endmodule

// ==== rtl/branch_unit.sv ====
`timescale 1ns/100ps
`include "idu_config.svh"

module branch_unit import idu_pkg::*; (
  input  inst_word_u            inst,
  input  logic [`BR_KIND_W-1:0] br_kind,
  input  logic [`XLEN-1:0]      pc,
  input  logic [`XLEN-1:0]      rj_value,
  input  logic [`XLEN-1:0]      rkd_value,
  input  logic                  fire,
  output logic                  br_taken,
  output logic [`XLEN-1:0]      br_target
);

  logic             eq, lt, ltu;
  logic             cond;
  logic [`XLEN-1:0] offs16;
  logic [`XLEN-1:0] offs26;

  assign eq  = rj_value == rkd_value;
  assign lt  = $signed(rj_value) < $signed(rkd_value);
  assign ltu = rj_value < rkd_value;

  assign offs16 = {{(`XLEN-18){inst.ri16.offs[15]}}, inst.ri16.offs, 2'b00};
  assign offs26 = {{(`XLEN-28){inst.ri16.rj[4]}}, inst.ri16.rj, inst.ri16.rd,
                   inst.ri16.offs, 2'b00};       // b/bl offset spans rj, rd and offs

  always_comb begin
    case (br_kind)
      `BR_EQ:                cond = eq;
      `BR_NE:                cond = !eq;
      `BR_LT:                cond = lt;
      `BR_GE:                cond = !lt;
      `BR_LTU:               cond = ltu;
      `BR_GEU:               cond = !ltu;
      `BR_ALWAYS, `BR_JIRL:  cond = 1'b1;
      default:               cond = 1'b0;
    endcase
  end

  assign br_taken  = cond & fire;   // only once the branch leaves ID
  assign br_target = (br_kind == `BR_ALWAYS) ? pc + offs26
                   : (br_kind == `BR_JIRL)   ? rj_value + offs16
                   : pc + offs16;

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/100ps
`include "idu_config.svh"

module decode_stage import idu_pkg::*; (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   if_valid,
  input  inst_word_u             if_inst,
  input  logic [`XLEN-1:0]       if_pc,
  output logic                   id_allowin,
  input  logic                   ex_allowin,
  output logic                   out_valid,
  input  logic                   ex_fwd_we,
  input  logic                   ex_fwd_is_load,
  input  logic [`GPR_ADDR_W-1:0] ex_fwd_waddr,
  input  logic [`XLEN-1:0]       ex_fwd_wdata,
  input  logic                   mem_fwd_we,
  input  logic [`GPR_ADDR_W-1:0] mem_fwd_waddr,
  input  logic [`XLEN-1:0]       mem_fwd_wdata,
  input  logic                   wb_we,
  input  logic [`GPR_ADDR_W-1:0] wb_waddr,
  input  logic [`XLEN-1:0]       wb_wdata,
  output logic [`ALU_OP_W-1:0]   alu_op,
  output logic [`XLEN-1:0]       alu_src1,
  output logic [`XLEN-1:0]       alu_src2,
  output logic [`XLEN-1:0]       store_data,
  output logic [`XLEN-1:0]       pc_out,
  output logic                   load,
  output logic                   store,
  output logic                   rf_we,
  output logic [`GPR_ADDR_W-1:0] rf_waddr,
  output logic                   br_taken,
  output logic [`XLEN-1:0]       br_target
);

  logic                   id_valid;
  inst_word_u             id_inst;
  logic [`XLEN-1:0]       id_pc;
  logic                   accept;
  logic                   fire;
  logic                   stall;
  logic                   src1_is_pc, src2_is_imm;
  logic                   use_rj, use_rkd, rkd_is_rd;
  logic [`XLEN-1:0]       imm;
  logic [`BR_KIND_W-1:0]  br_kind;
  logic [`GPR_ADDR_W-1:0] rf_raddr2;
  logic [`XLEN-1:0]       rf_rdata1, rf_rdata2;
  logic [`XLEN-1:0]       rj_value, rkd_value;

  assign out_valid  = id_valid & ~stall;
  assign id_allowin = ~id_valid | (~stall & ex_allowin);
  assign fire       = out_valid & ex_allowin;
  assign accept     = if_valid & id_allowin & ~br_taken;  // wrong-path word is dropped

  always_ff @(posedge clk) begin
    if (!resetn) begin
      id_valid <= 1'b0;
    end else if (br_taken) begin
      id_valid <= 1'b0;
    end else if (id_allowin) begin
      id_valid <= if_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      id_inst <= '0;          // zero word decodes as a no-op
    end else if (accept) begin
      id_inst <= if_inst;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      id_pc <= if_pc;
    end
  end

  inst_decoder u_dec (
    .inst        (id_inst),
    .alu_op      (alu_op),
    .src1_is_pc  (src1_is_pc),
    .src2_is_imm (src2_is_imm),
    .use_rj      (use_rj),
    .use_rkd     (use_rkd),
    .rkd_is_rd   (rkd_is_rd),
    .load        (load),
    .store       (store),
    .rf_we       (rf_we),
    .rf_waddr    (rf_waddr),
    .imm         (imm),
    .br_kind     (br_kind)
  );

  assign rf_raddr2 = rkd_is_rd ? id_inst.r3.rd : id_inst.r3.rk;

  gpr_file u_gpr (
    .clk    (clk),
    .raddr1 (id_inst.r3.rj),
    .raddr2 (rf_raddr2),
    .we     (wb_we),
    .waddr  (wb_waddr),
    .wdata  (wb_wdata),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2)
  );

  operand_bypass u_byp (
    .raddr1         (id_inst.r3.rj),
    .raddr2         (rf_raddr2),
    .rdata1         (rf_rdata1),
    .rdata2         (rf_rdata2),
    .use_rj         (use_rj),
    .use_rkd        (use_rkd),
    .ex_fwd_we      (ex_fwd_we),
    .ex_fwd_is_load (ex_fwd_is_load),
    .ex_fwd_waddr   (ex_fwd_waddr),
    .ex_fwd_wdata   (ex_fwd_wdata),
    .mem_fwd_we     (mem_fwd_we),
    .mem_fwd_waddr  (mem_fwd_waddr),
    .mem_fwd_wdata  (mem_fwd_wdata),
    .wb_we          (wb_we),
    .wb_waddr       (wb_waddr),
    .wb_wdata       (wb_wdata),
    .rj_value       (rj_value),
    .rkd_value      (rkd_value),
    .stall          (stall)
  );

  branch_unit u_br (
    .inst      (id_inst),
    .br_kind   (br_kind),
    .pc        (id_pc),
    .rj_value  (rj_value),
    .rkd_value (rkd_value),
    .fire      (fire),
    .br_taken  (br_taken),
    .br_target (br_target)
  );

  assign alu_src1   = src1_is_pc ? id_pc : rj_value;
  assign alu_src2   = src2_is_imm ? imm : rkd_value;
  assign store_data = rkd_value;
  assign pc_out     = id_pc;

endmodule

// ==== tb/tb_decode_stage.sv ====
`timescale 1ns/100ps
`include "idu_config.svh"

module tb_decode_stage import idu_pkg::*; ();

  typedef struct {
    logic [31:0]            inst;
    logic [`XLEN-1:0]       pc;
    logic                   ex_we, ex_ld, mem_we, wb_we, ex_allowin;
    logic [`GPR_ADDR_W-1:0] ex_addr, mem_addr, wb_addr;
    logic [`XLEN-1:0]       ex_data, mem_data, wb_data;
    logic [`ALU_OP_W-1:0]   e_op;
    logic [`XLEN-1:0]       e_src1, e_src2, e_sd, e_target;
    logic                   e_rf_we, e_load, e_store, e_br, e_cond, e_valid;
    logic [`GPR_ADDR_W-1:0] e_waddr;
  } entry_t;

  logic clk, resetn, if_valid, ex_allowin, id_allowin, out_valid;
  inst_word_u if_inst;
  logic [`XLEN-1:0] if_pc, ex_fwd_wdata, mem_fwd_wdata, wb_wdata;
  logic ex_fwd_we, ex_fwd_is_load, mem_fwd_we, wb_we;
  logic [`GPR_ADDR_W-1:0] ex_fwd_waddr, mem_fwd_waddr, wb_waddr, rf_waddr;
  logic [`ALU_OP_W-1:0] alu_op;
  logic [`XLEN-1:0] alu_src1, alu_src2, store_data, pc_out, br_target;
  logic load, store, rf_we, br_taken;

  logic [`XLEN-1:0] rf_model [`GPR_NUM];
  logic [31:0]      lcg_state;
  entry_t           cur;
  entry_t           tab [$];

  decode_stage dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] r3(logic [16:0] op, logic [4:0] rk, logic [4:0] rj,
                                     logic [4:0] rd);
    return {op, rk, rj, rd};
  endfunction

  function automatic logic [31:0] ri12(logic [9:0] op, logic [11:0] imm, logic [4:0] rj,
                                       logic [4:0] rd);
    return {op, imm, rj, rd};
  endfunction

  function automatic logic [31:0] ri16(logic [5:0] op, logic [15:0] offs, logic [4:0] rj,
                                       logic [4:0] rd);
    return {op, offs, rj, rd};
  endfunction

  function automatic logic [`ALU_OP_W-1:0] onehot(int b);
    return `ALU_OP_W'(1) << b;
  endfunction

  function automatic logic [`XLEN-1:0] sext12(logic [11:0] x);
    return {{20{x[11]}}, x};
  endfunction

  // freshest producer of a register: EX, then MEM, then WB, then the file
  function automatic logic [`XLEN-1:0] fwd_val(logic [4:0] a);
    if (a == 0) return '0;
    if (cur.ex_we && cur.ex_addr == a) return cur.ex_data;
    if (cur.mem_we && cur.mem_addr == a) return cur.mem_data;
    if (cur.wb_we && cur.wb_addr == a) return cur.wb_data;
    return rf_model[a];
  endfunction

  function automatic logic cond_of(int k, logic [31:0] a, logic [31:0] b);
    case (k)
      0: return a == b;
      1: return a != b;
      2: return $signed(a) < $signed(b);
      3: return !($signed(a) < $signed(b));
      4: return a < b;
      default: return !(a < b);
    endcase
  endfunction

  task automatic begin_entry(logic [31:0] inst);
    cur = '{default: '0};
    cur.inst = inst;
    cur.pc = 32'h1c00_0200 + 32'(tab.size()) * 32'd4;  // one pc per entry
    cur.ex_allowin = 1'b1;
    cur.e_valid = 1'b1;
  endtask

  // operand defaults, rkd_rd picks rd as second source
  task automatic set_operands(logic rkd_rd);
    cur.e_src1 = fwd_val(cur.inst[9:5]);
    cur.e_sd = fwd_val(rkd_rd ? cur.inst[4:0] : cur.inst[14:10]);
    cur.e_src2 = cur.e_sd;
  endtask

  task automatic set_ctl(logic [`ALU_OP_W-1:0] op, logic we, logic [4:0] wa, logic ld,
                         logic st);
    cur.e_op = op;
    cur.e_rf_we = we;
    cur.e_waddr = wa;
    cur.e_load = ld;
    cur.e_store = st;
  endtask

  task automatic fail_value(string name, logic [31:0] got, logic [31:0] exp);
    $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_word(string name, logic [`XLEN-1:0] got, logic [`XLEN-1:0] exp);
    if (got !== exp) fail_value(name, got, exp);
  endtask

  task automatic check_op(string name, logic [`ALU_OP_W-1:0] got, logic [`ALU_OP_W-1:0] exp);
    if (got !== exp) fail_value(name, 32'(got), 32'(exp));
  endtask

  task automatic check_addr(string name, logic [`GPR_ADDR_W-1:0] got,
                            logic [`GPR_ADDR_W-1:0] exp);
    if (got !== exp) fail_value(name, 32'(got), 32'(exp));
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) fail_value(name, 32'(got), 32'(exp));
  endtask

  task automatic wait_allowin();
    int n;
    n = 0;
    while (id_allowin !== 1'b1) begin
      n++;
      if (n > 20) begin
        $display("timeout while waiting for id_allowin to rise");
        $display("test failed");
        $fatal(1);
      end
      @(posedge clk);
      #2;
    end
  endtask

  task automatic check_outputs(entry_t e);
    check_op("alu_op", alu_op, e.e_op);
    check_word("alu_src1", alu_src1, e.e_src1);
    check_word("alu_src2", alu_src2, e.e_src2);
    check_word("store_data", store_data, e.e_sd);
    check_word("pc_out", pc_out, e.pc);
    check_bit("rf_we", rf_we, e.e_rf_we);
    check_addr("rf_waddr", rf_waddr, e.e_waddr);
    check_bit("load", load, e.e_load);
    check_bit("store", store, e.e_store);
    check_bit("out_valid", out_valid, e.e_valid);
    check_bit("id_allowin", id_allowin, e.e_valid & e.ex_allowin);
    check_bit("br_taken", br_taken, e.e_cond & e.e_valid & e.ex_allowin);
    if (e.e_br) check_word("br_target", br_target, e.e_target);
  endtask

  task automatic clear_fwd();
    ex_fwd_we = 0;
    ex_fwd_is_load = 0;
    ex_fwd_waddr = 0;
    ex_fwd_wdata = 0;
    mem_fwd_we = 0;
    mem_fwd_waddr = 0;
    mem_fwd_wdata = 0;
    wb_we = 0;
    wb_waddr = 0;
    wb_wdata = 0;
  endtask

  task automatic apply_entry(entry_t e);
    logic hold;
    hold = !e.ex_allowin || !e.e_valid;
    if_valid = 1'b1;
    if_inst = e.inst;
    if_pc = e.pc;
    ex_allowin = 1'b1;
    wait_allowin();
    @(posedge clk);
    #2;
    if_valid = hold;            // a held stage must leave this word waiting
    if_pc = ~e.pc;
    ex_fwd_we = e.ex_we;
    ex_fwd_is_load = e.ex_ld;
    ex_fwd_waddr = e.ex_addr;
    ex_fwd_wdata = e.ex_data;
    mem_fwd_we = e.mem_we;
    mem_fwd_waddr = e.mem_addr;
    mem_fwd_wdata = e.mem_data;
    wb_we = e.wb_we;
    wb_waddr = e.wb_addr;
    wb_wdata = e.wb_data;
    ex_allowin = e.ex_allowin;
    #5;
    check_outputs(e);
    if (hold) begin             // held instruction stays put
      @(posedge clk);
      #2;
      check_outputs(e);
    end
    clear_fwd();
    ex_allowin = 1'b1;
    if_valid = e.e_cond;        // wrong-path word behind a taken branch
    #1;
    check_bit("out_valid", out_valid, 1'b1);
    check_bit("br_taken", br_taken, e.e_cond);
    @(posedge clk);
    #2;
    check_bit("out_valid", out_valid, 1'b0);
    if_valid = 1'b0;
  endtask

  task automatic build_table();
    logic [16:0] r3_ops [11] = '{17'h20, 17'h22, 17'h24, 17'h25, 17'h28, 17'h29,
                                 17'h2a, 17'h2b, 17'h2e, 17'h2f, 17'h30};
    int          r3_bits [11] = '{`ALU_ADD, `ALU_SUB, `ALU_SLT, `ALU_SLTU, `ALU_NOR,
                                  `ALU_AND, `ALU_OR, `ALU_XOR, `ALU_SLL, `ALU_SRL, `ALU_SRA};
    logic [9:0]  i_ops [6] = '{10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f};
    int          i_bits [6] = '{`ALU_SLT, `ALU_SLTU, `ALU_ADD, `ALU_AND, `ALU_OR, `ALU_XOR};
    logic [16:0] s_ops [3] = '{17'h81, 17'h89, 17'h91};
    int          s_bits [3] = '{`ALU_SLL, `ALU_SRL, `ALU_SRA};
    logic [4:0]  pr_rj [3] = '{5'd4, 5'd5, 5'd4};
    logic [4:0]  pr_rd [3] = '{5'd5, 5'd4, 5'd4};
    for (int i = 0; i < 11; i++) begin
      begin_entry(r3(r3_ops[i], 5, 4, 5'(3 + i)));
      set_operands(0);
      set_ctl(onehot(r3_bits[i]), 1, 5'(3 + i), 0, 0);
      tab.push_back(cur);
    end
    begin_entry(r3(17'h20, 0, 0, 3));           // r0 reads zero after a write
    set_operands(0);
    set_ctl(onehot(`ALU_ADD), 1, 3, 0, 0);
    tab.push_back(cur);
    for (int i = 0; i < 6; i++) begin
      begin_entry(ri12(i_ops[i], 12'h8f3, 6, 5'(20 + i)));
      set_operands(0);
      cur.e_src2 = (i < 3) ? sext12(12'h8f3) : 32'h0000_08f3;
      set_ctl(onehot(i_bits[i]), 1, 5'(20 + i), 0, 0);
      tab.push_back(cur);
    end
    for (int i = 0; i < 3; i++) begin
      begin_entry(r3(s_ops[i], 3, 7, 5'(26 + i)));
      set_operands(0);
      cur.e_src2 = sext12(cur.inst[21:10]);
      set_ctl(onehot(s_bits[i]), 1, 5'(26 + i), 0, 0);
      tab.push_back(cur);
    end
    begin_entry({7'h0a, 20'h12345, 5'd11});      // lu12i.w
    set_operands(0);
    cur.e_src2 = 32'h1234_5000;
    set_ctl(onehot(`ALU_LUI), 1, 11, 0, 0);
    tab.push_back(cur);
    begin_entry({7'h0e, 20'h00003, 5'd12});      // pcaddu12i
    set_operands(0);
    cur.e_src1 = cur.pc;
    cur.e_src2 = 32'h0000_3000;
    set_ctl(onehot(`ALU_ADD), 1, 12, 0, 0);
    tab.push_back(cur);
    begin_entry(ri12(10'h0a2, 12'h008, 4, 13));
    set_operands(0);
    cur.e_src2 = 32'h8;
    set_ctl(onehot(`ALU_ADD), 1, 13, 1, 0);
    tab.push_back(cur);
    begin_entry(ri12(10'h0a6, 12'hffc, 4, 14));
    set_operands(1);
    cur.e_src2 = 32'hffff_fffc;
    set_ctl(onehot(`ALU_ADD), 0, 0, 0, 1);
    tab.push_back(cur);
    begin_entry(32'hffff_ffff);                 // unknown word
    set_operands(0);
    tab.push_back(cur);
    for (int i = 0; i < 4; i++) begin           // forwarding priority
      begin_entry(r3(17'h20, 7, (i == 3) ? 5'd0 : 5'd6, 3));
      cur.ex_we = (i == 0 || i == 3);
      cur.ex_addr = (i == 3) ? 5'd0 : 5'd6;
      cur.ex_data = 32'haaaa_0001;
      cur.mem_we = (i < 2);
      cur.mem_addr = 6;
      cur.mem_data = 32'hbbbb_0002;
      cur.wb_we = (i < 3);
      cur.wb_addr = 6;
      cur.wb_data = 32'hcccc_0003;
      set_operands(0);
      set_ctl(onehot(`ALU_ADD), 1, 3, 0, 0);
      tab.push_back(cur);
    end
    for (int i = 0; i < 3; i++) begin           // load-use
      if (i < 2) begin_entry(r3(17'h20, 7, 6, 3));
      else begin_entry(ri12(10'h00a, 12'h007, 6, 3));
      cur.ex_we = 1;
      cur.ex_ld = 1;
      cur.ex_addr = (i == 1) ? 5'd8 : 5'd7;
      cur.ex_data = 32'hdddd_0004;
      set_operands(0);
      if (i == 2) cur.e_src2 = 32'h7;
      set_ctl(onehot(`ALU_ADD), 1, 3, 0, 0);
      cur.e_valid = (i != 0);
      tab.push_back(cur);
    end
    for (int k = 0; k < 6; k++) begin
      for (int p = 0; p < 3; p++) begin
        begin_entry(ri16(6'(6'h16 + k), 16'hfff0, pr_rj[p], pr_rd[p]));
        set_operands(1);
        cur.e_br = 1;
        cur.e_cond = cond_of(k, rf_model[pr_rj[p]], rf_model[pr_rd[p]]);
        cur.e_target = cur.pc - 32'd64;
        tab.push_back(cur);
      end
    end
    begin_entry({6'h14, 16'h0040, 10'h3ff});    // b, negative 26-bit offset
    set_operands(0);
    cur.e_br = 1;
    cur.e_cond = 1;
    cur.e_target = cur.pc + {{4{1'b1}}, 10'h3ff, 16'h0040, 2'b00};
    tab.push_back(cur);
    begin_entry({6'h15, 16'h0100, 10'h000});    // bl
    set_operands(0);
    cur.e_src1 = cur.pc;
    cur.e_src2 = 32'h4;
    set_ctl(onehot(`ALU_ADD), 1, `RA_REG, 0, 0);
    cur.e_br = 1;
    cur.e_cond = 1;
    cur.e_target = cur.pc + 32'h400;
    tab.push_back(cur);
    begin_entry(ri16(6'h13, 16'h0010, 4, 2));    // jirl
    set_operands(0);
    cur.e_src1 = cur.pc;
    cur.e_src2 = 32'h4;
    set_ctl(onehot(`ALU_ADD), 1, 2, 0, 0);
    cur.e_br = 1;
    cur.e_cond = 1;
    cur.e_target = rf_model[4] + 32'h40;
    tab.push_back(cur);
    begin_entry(ri16(6'h16, 16'h0008, 4, 4));    // taken beq under back-pressure
    set_operands(1);
    cur.ex_allowin = 0;
    cur.e_br = 1;
    cur.e_cond = 1;
    cur.e_target = cur.pc + 32'h20;
    tab.push_back(cur);
  endtask

  initial begin
    lcg_state = 32'h1243;
    resetn = 0;
    if_valid = 0;
    if_inst = '0;
    if_pc = '0;
    ex_allowin = 1;
    clear_fwd();
    repeat (4) @(posedge clk);
    #2;
    resetn = 1;
    #1;
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("br_taken", br_taken, 1'b0);
    check_bit("id_allowin", id_allowin, 1'b1);
    for (int i = 0; i < `GPR_NUM; i++) begin   // preload through WB
      wb_we = 1;
      wb_waddr = 5'(i);
      wb_wdata = lcg_next();
      rf_model[i] = (i == 0) ? '0 : wb_wdata;
      @(posedge clk);
      #2;
    end
    clear_fwd();
    build_table();
    foreach (tab[i]) apply_entry(tab[i]);
    $display("test passed");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/idu_pkg.sv
rtl/gpr_file.sv
rtl/inst_decoder.sv
rtl/operand_bypass.sv
rtl/branch_unit.sv
rtl/decode_stage.sv
tb/tb_decode_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_decode_stage \
  -f list.f \
  -o sim_tb_decode_stage

./obj_dir/sim_tb_decode_stage
